//--- sim/state_window_golden.txt
# State: ten lines of five 32-bit words, word 0 first
# Commands: op (0 read, 1 write), byte address, swap, expected unmasked word
00000001 8000000a deadbeef 01234567 89abcdef
0000808b 80000001 80008081 00008009 0000008a
00000088 80008009 8000000a 8000808b 0000008b
00008089 00008003 00008002 00000080 0000800a
8000000a 80008081 00008080 80000001 80008008
a5a5a5a5 5a5a5a5a 0f1e2d3c 4b5a6978 8796a5b4
c3d2e1f0 11223344 55667788 99aabbcc ddeeff00
cafef00d feedface 0badc0de 13579bdf 2468ace0
7f7f0101 00ff00ff ff00ff00 3c3c3c3c c3c3c3c3
6b8b4567 327b23c6 643c9869 66334873 74b0dc51
# Command list
0 000 0 00000001
0 008 1 efbeadde
1 00c 0 00000000
0 00c 0 01234567
1 10c 0 00000000
0 00f 0 01234567
0 0c4 0 74b0dc51
0 0c4 1 51dcb074
0 0c8 0 00000000
0 0fc 1 00000000
0 084 1 ccbbaa99
1 000 0 00000000
0 064 0 a5a5a5a5
0 000 0 00000001

//--- sources.f
logic/keccak_pkg.sv
logic/bus_pkg.sv
logic/state_capture.sv
logic/bus_adapter.sv
logic/kmac_staterd.sv
logic/keccak_state_window.sv
sim/state_window_checker.sv
sim/state_window_assert.sv
sim/tb_keccak_state_window.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the state window testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_keccak_state_window \
  --Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_keccak_state_window)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

//--- sim/tb_keccak_state_window.sv
//////////////////////////////////////////////////
// Testbench for the Keccak state window
// Loads a golden state, sweeps both shares and
// replays the golden command list
//////////////////////////////////////////////////

module tb_keccak_state_window;

  timeunit 1ns;
  timeprecision 100ps;

  import keccak_pkg::*;
  import bus_pkg::*;

  localparam int MaxCmds    = 32;
  localparam int SweepReads = 2 * 64;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        load;
  logic        endian_swap;
  state_t      state;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;

  logic [31:0] gold_words [StateWords];
  logic [31:0] cmd_op     [MaxCmds];
  logic [31:0] cmd_addr   [MaxCmds];
  logic [31:0] cmd_swap   [MaxCmds];
  logic [31:0] cmd_exp    [MaxCmds];
  int          n_words;
  int          n_cmds;
  int          cycles = 0;
  int          limit  = 2 * (SweepReads + MaxCmds) + 40;

  always #50 clk = ~clk;

  keccak_state_window i_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .bus_req_i     (bus_req),
    .bus_rsp_o     (bus_rsp),
    .load_i        (load),
    .state_i       (state),
    .endian_swap_i (endian_swap)
  );

  state_window_checker u_checker (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .bus_rsp_i (bus_rsp)
  );

  // Byte b of the result is byte 3-b of the input
  function automatic logic [31:0] byte_reverse(input logic [31:0] w);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = w[8*(3-b) +: 8];
    end
    return r;
  endfunction

  // Ten state lines first, every later line is a command
  task automatic read_golden(output bit ok);
    int    fd;
    int    n;
    string line;
    logic [31:0] v [5];
    n_words = 0;
    n_cmds  = 0;
    fd = $fopen("sim/state_window_golden.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() < 2 || line.getc(0) == "#") continue;
        if (n_words < StateWords) begin
          n = $sscanf(line, "%h %h %h %h %h", v[0], v[1], v[2], v[3], v[4]);
          for (int k = 0; k < 5; k++) gold_words[n_words + k] = v[k];
          n_words += 5;
        end else if (n_cmds < MaxCmds) begin
          n = $sscanf(line, "%h %h %h %h", cmd_op[n_cmds], cmd_addr[n_cmds],
                      cmd_swap[n_cmds], cmd_exp[n_cmds]);
          n_cmds++;
        end
      end
      $fclose(fd);
      ok = (n_words == StateWords) && (n_cmds > 0);
    end
  endtask

  task automatic issue(input bus_op_e op, input logic [BusAddrW-1:0] addr,
                       input logic swap);
    @(posedge clk);
    bus_req.req   <= 1'b1;
    bus_req.op    <= op;
    bus_req.addr  <= addr;
    bus_req.wdata <= 32'hffff_ffff;
    endian_swap   <= swap;
  endtask

  // Share 0 then share 1, back to back
  task automatic read_pair(input logic [BusAddrW-1:0] addr, input logic swap,
                           input logic [31:0] expected);
    logic past_state;
    // Word indices 50 to 63 lie outside the state
    past_state = (int'(addr[WordIdxW+1:2]) >= StateWords);
    u_checker.push_read(expected, past_state);
    issue(OpRead, addr, swap);
    issue(OpRead, addr | 9'h100, swap);
  endtask

  task automatic write_once(input logic [BusAddrW-1:0] addr);
    u_checker.push_write();
    issue(OpWrite, addr, 1'b0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: responses missing");
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////

  initial begin
    bit          ok;
    logic [31:0] expected;
    rst_n       = 1'b0;
    load        = 1'b0;
    endian_swap = 1'b0;
    state       = '0;
    bus_req     = '0;
    u_checker.err_cnt   = 0;
    u_checker.check_cnt = 0;
    read_golden(ok);
    if (!ok) begin
      $display("Golden file missing or incomplete");
      $display("Testbench failed");
      $finish;
    end else begin
      limit = 2 * (SweepReads + n_cmds) + 40;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < StateWords; i++) state[32*i +: 32] <= gold_words[i];
      load <= 1'b1;
      @(posedge clk);
      load <= 1'b0;
      // Full sweep, plain then swapped, including words past the state
      for (int s = 0; s < 2; s++) begin
        for (int w = 0; w < 64; w++) begin
          expected = (w < StateWords) ? gold_words[w] : 32'h0;
          if (s == 1) expected = byte_reverse(expected);
          read_pair(9'(w * 4), s[0], expected);
        end
      end
      for (int i = 0; i < n_cmds; i++) begin
        if (cmd_op[i] == 32'h0) begin
          read_pair(cmd_addr[i][BusAddrW-1:0], cmd_swap[i][0], cmd_exp[i]);
        end else begin
          write_once(cmd_addr[i][BusAddrW-1:0]);
        end
      end
      @(posedge clk);
      bus_req <= '0;
      while (u_checker.pending() > 0) @(posedge clk);
      // A few idle cycles to catch stray responses
      repeat (3) @(posedge clk);
      $display("errors %0d, checks %0d", u_checker.err_cnt, u_checker.check_cnt);
      if (u_checker.err_cnt == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

//--- sim/state_window_assert.sv
//////////////////////////////////////////////////
// Bus adapter assertions
// Response timing and reset values
//////////////////////////////////////////////////

module state_window_assert (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  bus_pkg::bus_req_t  bus_req_i,
  input  bus_pkg::bus_rsp_t  bus_rsp_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import bus_pkg::*;

  // One response per request, always in the next cycle
  rsp_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.req |=> bus_rsp_o.rvalid) else $error("request got no response");

  no_stray_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_o.rvalid |-> $past(bus_req_i.req)) else $error("response without request");

  err_has_no_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_o.err |-> (bus_rsp_o.rdata == '0)) else $error("error response carries data");

  rsp_idle_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (bus_rsp_o == '0)) else $error("response not cleared in reset");

endmodule

bind bus_adapter state_window_assert u_assert (
  .clk_i,
  .rst_ni,
  .bus_req_i,
  .bus_rsp_o
);

//--- sim/state_window_checker.sv
//////////////////////////////////////////////////
// Response checker for the state window
// Pairs share reads, xors them and compares with
// the expected unmasked word
//////////////////////////////////////////////////

module state_window_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  bus_pkg::bus_rsp_t  bus_rsp_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import bus_pkg::*;

  typedef struct packed {
    logic        is_write;
    logic        zero_shares;
    logic [31:0] data;
  } expect_t;

  expect_t     exp_q [$];
  logic        half_q;
  logic [31:0] share0_q;
  int          err_cnt;
  int          check_cnt;

  // Read expectation covers a share 0 and share 1 response pair
  task automatic push_read(input logic [31:0] data, input logic zero_shares);
    expect_t e;
    e.is_write    = 1'b0;
    e.zero_shares = zero_shares;
    e.data        = data;
    exp_q.push_back(e);
  endtask

  task automatic push_write();
    expect_t e;
    e.is_write    = 1'b1;
    e.zero_shares = 1'b0;
    e.data        = '0;
    exp_q.push_back(e);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  // Responses change on the rising edge, so look at the falling one
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q   <= 1'b0;
      share0_q <= '0;
    end else if (bus_rsp_i.rvalid) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived with no request outstanding");
        err_cnt++;
      end else if (exp_q[0].is_write) begin
        check_cnt++;
        if (bus_rsp_i.err !== 1'b1) begin
          $display("FAIL err expected %0h actual %0h", 1'b1, bus_rsp_i.err);
          err_cnt++;
        end
        if (bus_rsp_i.rdata !== 32'h0) begin
          $display("FAIL rdata expected %08h actual %08h", 32'h0, bus_rsp_i.rdata);
          err_cnt++;
        end
        void'(exp_q.pop_front());
      end else begin
        if (bus_rsp_i.err !== 1'b0) begin
          $display("Read was answered with an error");
          err_cnt++;
        end
        // Past the state each share reads zero on its own
        if (exp_q[0].zero_shares && (bus_rsp_i.rdata !== 32'h0)) begin
          $display("FAIL rdata expected %08h actual %08h", 32'h0, bus_rsp_i.rdata);
          err_cnt++;
        end
        if (!half_q) begin
          share0_q <= bus_rsp_i.rdata;
          half_q   <= 1'b1;
        end else begin
          check_cnt++;
          if ((share0_q ^ bus_rsp_i.rdata) !== exp_q[0].data) begin
            $display("FAIL rdata expected %08h actual %08h",
                     exp_q[0].data, share0_q ^ bus_rsp_i.rdata);
            err_cnt++;
          end
          half_q <= 1'b0;
          void'(exp_q.pop_front());
        end
      end
    end
  end

endmodule

//--- logic/keccak_state_window.sv
//////////////////////////////////////////////////
// Keccak state readback window
// Read-only register view of the captured state
//////////////////////////////////////////////////

module keccak_state_window #(
  parameter  bit EnMasking = 1'b1,
  localparam int Share     = EnMasking ? keccak_pkg::MaxShare : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  bus_pkg::bus_req_t   bus_req_i,
  output bus_pkg::bus_rsp_t   bus_rsp_o,

  input  logic                load_i,
  input  keccak_pkg::state_t  state_i,

  input  logic                endian_swap_i
);

  import keccak_pkg::*;
  import bus_pkg::*;

  state_t              shares [Share];
  logic                rd_req;
  logic [BusAddrW-3:0] rd_addr;
  logic                rd_valid;
  logic [31:0]         rd_data;

  state_capture #(
    .EnMasking (EnMasking)
  ) u_capture (
    .clk_i,
    .rst_ni,
    .load_i,
    .state_i,
    .shares_o (shares)
  );

  bus_adapter u_adapter (
    .clk_i,
    .rst_ni,
    .bus_req_i,
    .bus_rsp_o,
    .rd_req_o   (rd_req),
    .rd_addr_o  (rd_addr),
    .rd_valid_i (rd_valid),
    .rd_data_i  (rd_data)
  );

  kmac_staterd #(
    .EnMasking (EnMasking)
  ) u_staterd (
    .clk_i,
    .rst_ni,
    .rd_req_i      (rd_req),
    .rd_addr_i     (rd_addr),
    .shares_i      (shares),
    .endian_swap_i,
    .rd_valid_o    (rd_valid),
    .rd_data_o     (rd_data)
  );

endmodule

//--- logic/kmac_staterd.sv
//////////////////////////////////////////////////
// Keccak state reader
// Picks share and word by address, swaps bytes
// on request and registers the read data
//////////////////////////////////////////////////

module kmac_staterd #(
  parameter  bit EnMasking = 1'b1,
  localparam int Share     = EnMasking ? keccak_pkg::MaxShare : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          rd_req_i,
  input  logic [bus_pkg::BusAddrW-3:0]  rd_addr_i,

  input  keccak_pkg::state_t            shares_i [Share],
  input  logic                          endian_swap_i,

  output logic                          rd_valid_o,
  output logic [31:0]                   rd_data_o
);

  import keccak_pkg::*;
  import bus_pkg::*;

  logic [WordIdxW-1:0]            word_idx;
  logic [BusAddrW-3-WordIdxW:0]   share_sel;
  logic [31:0]                    share_word [Share];
  logic [31:0]                    muxed_word;

  assign word_idx  = rd_addr_i[WordIdxW-1:0];
  assign share_sel = rd_addr_i[BusAddrW-3:WordIdxW];

  ////////////////////////////////////////////////
  // Word slicing
  ////////////////////////////////////////////////

  // Words 50 to 63 lie past the state and read zero
  for (genvar i = 0; i < Share; i++) begin : gen_slicer
    assign share_word[i] = (int'(word_idx) < StateWords) ?
                           shares_i[i][32*word_idx +: 32] : '0;
  end : gen_slicer

  // Unused share slots read zero too
  assign muxed_word = (int'(share_sel) < Share) ? share_word[share_sel] : '0;

  ////////////////////////////////////////////////
  // Read data register
  ////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_o <= '0;
    end else if (rd_req_i) begin
      rd_data_o <= conv_endian32(muxed_word, endian_swap_i);
    end
  end

endmodule

//--- logic/bus_adapter.sv
//////////////////////////////////////////////////
// Bus adapter for the state window
// Passes reads on to the state reader and
// answers writes with an error response
//////////////////////////////////////////////////

module bus_adapter (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  bus_pkg::bus_req_t             bus_req_i,
  output bus_pkg::bus_rsp_t             bus_rsp_o,

  // Word read port towards the state reader
  output logic                          rd_req_o,
  output logic [bus_pkg::BusAddrW-3:0]  rd_addr_o,
  input  logic                          rd_valid_i,
  input  logic [31:0]                   rd_data_i
);

  import bus_pkg::*;

  logic is_read;
  logic is_write;
  logic wr_err_q;

  ////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////

  assign is_read  = bus_req_i.req & (bus_req_i.op == OpRead);
  assign is_write = bus_req_i.req & (bus_req_i.op == OpWrite);

  // Byte offset dropped, no byte-masked access
  assign rd_req_o  = is_read;
  assign rd_addr_o = bus_req_i.addr[BusAddrW-1:2];

  // Write error answered one cycle later, like a read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_err_q <= 1'b0;
    end else begin
      wr_err_q <= is_write;
    end
  end

  ////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////

  // At most one of the two is set in a given cycle
  always_comb begin
    bus_rsp_o        = '0;
    bus_rsp_o.rvalid = rd_valid_i | wr_err_q;
    bus_rsp_o.err    = wr_err_q;
    // Data only with a read response
    if (rd_valid_i) begin
      bus_rsp_o.rdata = rd_data_i;
    end
  end

endmodule

//--- logic/state_capture.sv
//////////////////////////////////////////////////
// Keccak state capture
// Loads the final state on a strobe and keeps it
// plain or split into two Boolean shares
//////////////////////////////////////////////////

module state_capture #(
  parameter  bit EnMasking = 1'b1,
  localparam int Share     = EnMasking ? keccak_pkg::MaxShare : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                load_i,
  input  keccak_pkg::state_t  state_i,
  output keccak_pkg::state_t  shares_o [Share]
);

  import keccak_pkg::*;

  logic [31:0] lfsr_q;
  logic        lfsr_fb;
  logic [63:0] lfsr_dbl;
  state_t      mask;

  // x^32 + x^22 + x^2 + x + 1, free running
  assign lfsr_fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 32'h5a3c_96e1;
    end else begin
      lfsr_q <= {lfsr_q[30:0], lfsr_fb};
    end
  end

  // Mask word i is the LFSR value rotated left by i mod 32
  assign lfsr_dbl = {lfsr_q, lfsr_q};

  for (genvar i = 0; i < StateWords; i++) begin : gen_mask
    assign mask[32*i +: 32] = lfsr_dbl[63-(i%32) -: 32];
  end : gen_mask

  ////////////////////////////////////////////////
  // Share storage
  ////////////////////////////////////////////////

  if (EnMasking) begin : gen_masked
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        shares_o[0] <= '0;
        shares_o[1] <= '0;
      end else if (load_i) begin
        shares_o[0] <= mask;
        shares_o[1] <= state_i ^ mask;
      end
    end
  end else begin : gen_plain
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        shares_o[0] <= '0;
      end else if (load_i) begin
        shares_o[0] <= state_i;
      end
    end
  end

endmodule

//--- logic/bus_pkg.sv
//////////////////////////////////////////////////
// Register bus types
// Single-word request and response carried on
// plain strobes, no grant and no back-pressure
//////////////////////////////////////////////////

package bus_pkg;

  // Byte address, two shares of 256 bytes
  localparam int BusAddrW = 9;

  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } bus_op_e;

  ////////////////////////////////////////////////
  // Request from the host
  ////////////////////////////////////////////////

  typedef struct packed {
    logic                req;
    bus_op_e             op;
    logic [BusAddrW-1:0] addr;
    // Write data, the window is read-only
    logic [31:0]         wdata;
  } bus_req_t;

  ////////////////////////////////////////////////
  // Response, one cycle after the request
  ////////////////////////////////////////////////

  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

endpackage

//--- logic/keccak_pkg.sv
//////////////////////////////////////////////////
// Keccak state geometry
// Sponge state width, word layout of the readback
// window and the 32-bit byte-order helper
//////////////////////////////////////////////////

package keccak_pkg;

  // Full sponge state, 5x5 lanes of 64 bits
  localparam int StateW = 1600;

  // Number of 32-bit words in one share
  localparam int StateWords = StateW / 32;

  // Word select bits, 64 words or 256 bytes per share
  localparam int WordIdxW = 6;

  // Largest share count the window supports
  localparam int MaxShare = 2;

  typedef logic [StateW-1:0] state_t;

  // Byte reversal for big-endian readback
  function automatic logic [31:0] conv_endian32(input logic [31:0] word,
                                                input logic        swap);
    logic [31:0] swapped;
    swapped = {word[7:0], word[15:8], word[23:16], word[31:24]};
    return swap ? swapped : word;
  endfunction

endpackage
